//--- input_pkg.sv
/* Input decode definitions */

package input_pkg;

  // Recognized PS/2 set-2 scan codes
  typedef enum logic [7:0] {
    scan_up    = 8'h75,
    scan_down  = 8'h72,
    scan_left  = 8'h6b,
    scan_right = 8'h74,
    scan_ctrl  = 8'h14,
    scan_alt   = 8'h11,
    scan_space = 8'h29,
    scan_1     = 8'h16,
    scan_2     = 8'h1e,
    scan_5     = 8'h2e,
    scan_6     = 8'h36,
    scan_9     = 8'h46,
    scan_0     = 8'h45,
    scan_a     = 8'h1c,
    scan_s     = 8'h1b,
    scan_q     = 8'h15,
    scan_r     = 8'h2d,
    scan_f     = 8'h2b,
    scan_d     = 8'h23,
    scan_g     = 8'h34,
    scan_p     = 8'h4d
  } scan_code_e;

  // One held bit per recognized key
  localparam int key_state_w = 21;

  //////////////////////////////////////////////////
  // Key state vector layout
  //////////////////////////////////////////////////
  localparam int key_idx_up    = 0;
  localparam int key_idx_down  = 1;
  localparam int key_idx_left  = 2;
  localparam int key_idx_right = 3;
  localparam int key_idx_ctrl  = 4;
  localparam int key_idx_alt   = 5;
  localparam int key_idx_space = 6;
  localparam int key_idx_1     = 7;
  localparam int key_idx_2     = 8;
  localparam int key_idx_5     = 9;
  localparam int key_idx_6     = 10;
  localparam int key_idx_9     = 11;
  localparam int key_idx_0     = 12;
  localparam int key_idx_a     = 13;
  localparam int key_idx_s     = 14;
  localparam int key_idx_q     = 15;
  localparam int key_idx_r     = 16;
  localparam int key_idx_f     = 17;
  localparam int key_idx_d     = 18;
  localparam int key_idx_g     = 19;
  localparam int key_idx_p     = 20;

  //////////////////////////////////////////////////
  // Player control word, 10 bits
  //////////////////////////////////////////////////
  localparam int player_w        = 10;
  localparam int player_up       = 0;
  localparam int player_down     = 1;
  localparam int player_left     = 2;
  localparam int player_right    = 3;
  localparam int player_button_1 = 4;
  localparam int player_button_2 = 5;
  localparam int player_button_3 = 6;
  localparam int player_start    = 7;
  localparam int player_coin     = 8;
  localparam int player_service  = 9;

  //////////////////////////////////////////////////
  // Joystick word from the host bridge, 11 bits
  //////////////////////////////////////////////////
  localparam int joy_w       = 11;
  localparam int joy_right   = 0;
  localparam int joy_left    = 1;
  localparam int joy_down    = 2;
  localparam int joy_up      = 3;
  localparam int joy_b1      = 4;
  localparam int joy_b2      = 5;
  localparam int joy_b3      = 6;
  localparam int joy_start   = 7;
  localparam int joy_coin    = 8;
  localparam int joy_pause   = 9;
  localparam int joy_service = 10;

endpackage

//--- platform_pkg.sv
/* Platform glue definitions */

package platform_pkg;

  // Video aspect ratio selection
  typedef enum logic [1:0] {
    aspect_4_3,
    aspect_16_9,
    aspect_3_4
  } aspect_e;

  //////////////////////////////////////////////////
  // Menu status word bit positions
  //////////////////////////////////////////////////
  localparam int status_w            = 32;
  localparam int status_reset_bit    = 0;
  localparam int status_wide_bit     = 1;
  localparam int status_vertical_bit = 2;
  localparam int status_flip_bit     = 3;
  localparam int status_debug_bit    = 7;

  //////////////////////////////////////////////////
  // DDR word address mapping
  //////////////////////////////////////////////////
  localparam int ddr_addr_w = 29;

  // Top nibble of the DDR word address for the core window
  localparam logic [3:0] ddr_window = 4'b0011;

  // Byte address bits kept below the window
  localparam int ddr_byte_hi = 27;
  localparam int ddr_byte_lo = 3;

endpackage

//--- ps2_key_decoder.sv
/* PS/2 key event decoder */

module ps2_key_decoder (
  input  logic                               clk_sys,
  input  logic                               rst_n,
  input  logic [10:0]                        ps2_key,
  output logic [input_pkg::key_state_w-1:0]  key_state
);

  import input_pkg::*;

  localparam int idx_w = $clog2(key_state_w);

  // Fields of the bridge event word
  logic       toggle;
  logic       pressed;
  scan_code_e code;

  assign toggle  = ps2_key[10];
  assign pressed = ps2_key[9];
  assign code    = scan_code_e'(ps2_key[7:0]);

  // Toggle seen at the previous edge
  logic toggle_q;
  logic new_event;

  assign new_event = toggle ^ toggle_q;

  //////////////////////////////////////////////////
  // Scan code to key index lookup
  //////////////////////////////////////////////////
  logic             key_hit;
  logic [idx_w-1:0] key_sel;

  always_comb begin
    key_hit = 1'b1;
    key_sel = '0;
    case (code)
      scan_up:    key_sel = idx_w'(key_idx_up);
      scan_down:  key_sel = idx_w'(key_idx_down);
      scan_left:  key_sel = idx_w'(key_idx_left);
      scan_right: key_sel = idx_w'(key_idx_right);
      scan_ctrl:  key_sel = idx_w'(key_idx_ctrl);
      scan_alt:   key_sel = idx_w'(key_idx_alt);
      scan_space: key_sel = idx_w'(key_idx_space);
      scan_1:     key_sel = idx_w'(key_idx_1);
      scan_2:     key_sel = idx_w'(key_idx_2);
      scan_5:     key_sel = idx_w'(key_idx_5);
      scan_6:     key_sel = idx_w'(key_idx_6);
      scan_9:     key_sel = idx_w'(key_idx_9);
      scan_0:     key_sel = idx_w'(key_idx_0);
      scan_a:     key_sel = idx_w'(key_idx_a);
      scan_s:     key_sel = idx_w'(key_idx_s);
      scan_q:     key_sel = idx_w'(key_idx_q);
      scan_r:     key_sel = idx_w'(key_idx_r);
      scan_f:     key_sel = idx_w'(key_idx_f);
      scan_d:     key_sel = idx_w'(key_idx_d);
      scan_g:     key_sel = idx_w'(key_idx_g);
      scan_p:     key_sel = idx_w'(key_idx_p);
      // Unknown code, nothing to update
      default:    key_hit = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Held key latches
  //////////////////////////////////////////////////
  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      toggle_q  <= 1'b0;
      key_state <= '0;
    end else begin
      toggle_q <= toggle;
      // One key per event, pressed picks press or release
      if (new_event && key_hit) begin
        key_state[key_sel] <= pressed;
      end
    end
  end

endmodule

//--- player_input_merge.sv
/* Player control merge */

module player_input_merge (
  input  logic [input_pkg::key_state_w-1:0] key_state,
  input  logic [input_pkg::joy_w-1:0]       joystick_0,
  input  logic [input_pkg::joy_w-1:0]       joystick_1,
  output logic [input_pkg::player_w-1:0]    player_1,
  output logic [input_pkg::player_w-1:0]    player_2,
  output logic                              pause
);

  import input_pkg::*;

  //////////////////////////////////////////////////
  // Player 1 from arrows and left-hand keys
  //////////////////////////////////////////////////
  assign player_1[player_up]       = key_state[key_idx_up]    | joystick_0[joy_up];
  assign player_1[player_down]     = key_state[key_idx_down]  | joystick_0[joy_down];
  assign player_1[player_left]     = key_state[key_idx_left]  | joystick_0[joy_left];
  assign player_1[player_right]    = key_state[key_idx_right] | joystick_0[joy_right];
  assign player_1[player_button_1] = key_state[key_idx_ctrl]  | joystick_0[joy_b1];
  assign player_1[player_button_2] = key_state[key_idx_alt]   | joystick_0[joy_b2];
  assign player_1[player_button_3] = key_state[key_idx_space] | joystick_0[joy_b3];
  assign player_1[player_start]    = key_state[key_idx_1]     | joystick_0[joy_start];
  assign player_1[player_coin]     = key_state[key_idx_5]     | joystick_0[joy_coin];
  assign player_1[player_service]  = key_state[key_idx_9]     | joystick_0[joy_service];

  //////////////////////////////////////////////////
  // Player 2 from the RFDG cluster
  //////////////////////////////////////////////////
  assign player_2[player_up]       = key_state[key_idx_r] | joystick_1[joy_up];
  assign player_2[player_down]     = key_state[key_idx_f] | joystick_1[joy_down];
  assign player_2[player_left]     = key_state[key_idx_d] | joystick_1[joy_left];
  assign player_2[player_right]    = key_state[key_idx_g] | joystick_1[joy_right];
  assign player_2[player_button_1] = key_state[key_idx_a] | joystick_1[joy_b1];
  assign player_2[player_button_2] = key_state[key_idx_s] | joystick_1[joy_b2];
  assign player_2[player_button_3] = key_state[key_idx_q] | joystick_1[joy_b3];
  assign player_2[player_start]    = key_state[key_idx_2] | joystick_1[joy_start];
  assign player_2[player_coin]     = key_state[key_idx_6] | joystick_1[joy_coin];
  assign player_2[player_service]  = key_state[key_idx_0] | joystick_1[joy_service];

  // Shared pause, either pad can request it
  assign pause = key_state[key_idx_p]
               | joystick_0[joy_pause]
               | joystick_1[joy_pause];

endmodule

//--- reset_sequencer.sv
/* Reset sequencer */

module reset_sequencer #(
  parameter int reset_stages = 3
) (
  input  logic clk_sys,
  input  logic rst_n,
  input  logic pll_locked,
  input  logic menu_reset,
  input  logic user_button,
  output logic core_rst_n,
  output logic cpu_rst_n
);

  // Chain 0 is the core reset, chain 1 the CPU reset
  localparam int n_chains = 2;

  logic [n_chains-1:0] reset_req;

  // Platform sources hold both resets
  assign reset_req[0] = ~rst_n | ~pll_locked;
  // CPU also held by the menu and the user button
  assign reset_req[1] = reset_req[0] | menu_reset | user_button;

  //////////////////////////////////////////////////
  // Release synchronizers
  //////////////////////////////////////////////////
  logic [n_chains-1:0][reset_stages-1:0] sync_q;

  always_ff @(posedge clk_sys) begin
    for (int i = 0; i < n_chains; i++) begin
      if (reset_req[i]) begin
        // Active request clears the whole chain at once
        sync_q[i] <= '0;
      end else begin
        // Ones ripple toward the output
        sync_q[i] <= {sync_q[i][reset_stages-2:0], 1'b1};
      end
    end
  end

  // Last stage of each chain
  assign core_rst_n = sync_q[0][reset_stages-1];
  assign cpu_rst_n  = sync_q[1][reset_stages-1];

endmodule

//--- core_config.sv
/* Menu status decode and DDR mapping */

module core_config (
  input  logic                              clk_sys,
  input  logic                              rst_n,
  input  logic [platform_pkg::status_w-1:0] status,
  input  logic [31:0]                       core_ddr_addr,
  output logic [7:0]                        video_arx,
  output logic [7:0]                        video_ary,
  output logic                              flip,
  output logic                              debug,
  output logic [platform_pkg::ddr_addr_w-1:0] ddram_addr
);

  import platform_pkg::*;

  aspect_e aspect_q;

  //////////////////////////////////////////////////
  // Registered menu options
  //////////////////////////////////////////////////
  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      aspect_q <= aspect_4_3;
      flip     <= 1'b0;
      debug    <= 1'b0;
    end else begin
      // Wide wins over vertical
      if (status[status_wide_bit]) begin
        aspect_q <= aspect_16_9;
      end else if (status[status_vertical_bit]) begin
        aspect_q <= aspect_3_4;
      end else begin
        aspect_q <= aspect_4_3;
      end
      flip  <= status[status_flip_bit];
      debug <= status[status_debug_bit];
    end
  end

  // Ratio numbers for the HDMI scaler
  always_comb begin
    case (aspect_q)
      aspect_16_9: begin
        video_arx = 8'd16;
        video_ary = 8'd9;
      end
      aspect_3_4: begin
        video_arx = 8'd3;
        video_ary = 8'd4;
      end
      default: begin
        video_arx = 8'd4;
        video_ary = 8'd3;
      end
    endcase
  end

  // Byte address to 64-bit DDR word inside the window
  assign ddram_addr = {ddr_window, core_ddr_addr[ddr_byte_hi:ddr_byte_lo]};

endmodule

//--- arcade_io_top.sv
/* Arcade input and platform glue */

module arcade_io_top #(
  parameter int reset_stages = 3
) (
  input  logic        clk_sys,
  input  logic        rst_n,
  input  logic        pll_locked,
  input  logic [10:0] ps2_key,
  input  logic [10:0] joystick_0,
  input  logic [10:0] joystick_1,
  input  logic [31:0] status,
  input  logic        user_button,
  input  logic [31:0] core_ddr_addr,
  output logic [9:0]  player_1,
  output logic [9:0]  player_2,
  output logic        pause,
  output logic        core_rst_n,
  output logic        cpu_rst_n,
  output logic [7:0]  video_arx,
  output logic [7:0]  video_ary,
  output logic        flip,
  output logic        debug,
  output logic [28:0] ddram_addr
);

  import input_pkg::*;
  import platform_pkg::*;

  // Held keys between decoder and merge
  logic [key_state_w-1:0] key_state;

  // Menu reset request
  logic menu_reset;

  assign menu_reset = status[status_reset_bit];

  //////////////////////////////////////////////////
  // Controls
  //////////////////////////////////////////////////
  ps2_key_decoder u_ps2_key_decoder (
    .clk_sys   (clk_sys),
    .rst_n     (rst_n),
    .ps2_key   (ps2_key),
    .key_state (key_state)
  );

  player_input_merge u_player_input_merge (
    .key_state  (key_state),
    .joystick_0 (joystick_0),
    .joystick_1 (joystick_1),
    .player_1   (player_1),
    .player_2   (player_2),
    .pause      (pause)
  );

  //////////////////////////////////////////////////
  // Resets and configuration
  //////////////////////////////////////////////////
  reset_sequencer #(
    .reset_stages (reset_stages)
  ) u_reset_sequencer (
    .clk_sys     (clk_sys),
    .rst_n       (rst_n),
    .pll_locked  (pll_locked),
    .menu_reset  (menu_reset),
    .user_button (user_button),
    .core_rst_n  (core_rst_n),
    .cpu_rst_n   (cpu_rst_n)
  );

  core_config u_core_config (
    .clk_sys       (clk_sys),
    .rst_n         (rst_n),
    .status        (status),
    .core_ddr_addr (core_ddr_addr),
    .video_arx     (video_arx),
    .video_ary     (video_ary),
    .flip          (flip),
    .debug         (debug),
    .ddram_addr    (ddram_addr)
  );

endmodule

//--- arcade_io_assertions.sv
/* Reset and key assertions */

module arcade_io_assertions #(
  parameter int reset_stages = 3
) (
  input logic                              clk_sys,
  input logic                              rst_n,
  input logic                              menu_reset,
  input logic                              user_button,
  input logic                              core_rst_n,
  input logic                              cpu_rst_n,
  input logic [input_pkg::key_state_w-1:0] key_state
);

  // Count of failed properties
  int assert_errors = 0;

  // Edges since the menu or the button last held the CPU, saturating
  int quiet_edges = 0;

  always @(posedge clk_sys) begin
    if (menu_reset || user_button) begin
      quiet_edges <= 0;
    end else if (quiet_edges < reset_stages) begin
      quiet_edges <= quiet_edges + 1;
    end
  end

  //////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////
  resets_low_in_reset: assert property (@(posedge clk_sys)
    !rst_n |=> (!core_rst_n && !cpu_rst_n))
    else begin
      $error("core or CPU reset released while rst_n was low");
      assert_errors++;
    end

  // Platform sources only, so both chains match
  core_follows_cpu: assert property (@(posedge clk_sys)
    (quiet_edges >= reset_stages && !cpu_rst_n) |-> !core_rst_n)
    else begin
      $error("core reset released while CPU reset held by platform sources");
      assert_errors++;
    end

  keys_clear_after_reset: assert property (@(posedge clk_sys)
    !rst_n |=> (key_state == '0))
    else begin
      $error("key state not cleared by reset");
      assert_errors++;
    end

endmodule

//--- tb_arcade_io.sv
/* Arcade I/O testbench */

module tb_arcade_io;

  import input_pkg::*;
  import platform_pkg::*;

  localparam int tb_reset_stages = 3;

  logic        clk_sys = 1'b0;
  logic        rst_n;
  logic        pll_locked;
  logic [10:0] ps2_key;
  logic [10:0] joystick_0;
  logic [10:0] joystick_1;
  logic [31:0] status;
  logic        user_button;
  logic [31:0] core_ddr_addr;
  logic [9:0]  player_1;
  logic [9:0]  player_2;
  logic        pause;
  logic        core_rst_n;
  logic        cpu_rst_n;
  logic [7:0]  video_arx;
  logic [7:0]  video_ary;
  logic        flip;
  logic        debug;
  logic [28:0] ddram_addr;

  arcade_io_top #(
    .reset_stages (tb_reset_stages)
  ) UUT (
    .clk_sys       (clk_sys),
    .rst_n         (rst_n),
    .pll_locked    (pll_locked),
    .ps2_key       (ps2_key),
    .joystick_0    (joystick_0),
    .joystick_1    (joystick_1),
    .status        (status),
    .user_button   (user_button),
    .core_ddr_addr (core_ddr_addr),
    .player_1      (player_1),
    .player_2      (player_2),
    .pause         (pause),
    .core_rst_n    (core_rst_n),
    .cpu_rst_n     (cpu_rst_n),
    .video_arx     (video_arx),
    .video_ary     (video_ary),
    .flip          (flip),
    .debug         (debug),
    .ddram_addr    (ddram_addr)
  );

  bind arcade_io_top arcade_io_assertions #(
    .reset_stages (reset_stages)
  ) u_assertions (
    .clk_sys     (clk_sys),
    .rst_n       (rst_n),
    .menu_reset  (menu_reset),
    .user_button (user_button),
    .core_rst_n  (core_rst_n),
    .cpu_rst_n   (cpu_rst_n),
    .key_state   (key_state)
  );

  // 40 unit period
  always begin
    clk_sys = 1'b0;
    #20;
    clk_sys = 1'b1;
    #20;
  end

  //////////////////////////////////////////////////
  // Test table and reference model
  //////////////////////////////////////////////////
  typedef struct {
    string       name;
    logic [10:0] key;
    logic [10:0] joy0;
    logic [10:0] joy1;
    logic [31:0] status;
    logic [31:0] addr;
    logic [9:0]  exp_p1;
    logic [9:0]  exp_p2;
    logic        exp_pause;
    logic [7:0]  exp_arx;
    logic [7:0]  exp_ary;
    logic        exp_flip;
    logic        exp_debug;
    logic [28:0] exp_ddr;
  } row_t;

  row_t rows[$];

  // Held keys and toggle as the DUT should see them
  logic [20:0] model_keys;
  logic        model_toggle;

  // Scan code per key index, and key index per player bit
  logic [7:0] key_codes [21];
  int         p1_keys [10];
  int         p2_keys [10];
  int         joy_bits [10];

  // Bookkeeping
  int          pass_count;
  int          fail_count;
  int          cycle_count;
  int          timeout_limit;
  bit          test_ok;
  string       bad_field;
  logic [31:0] bad_exp;
  logic [31:0] bad_act;

  function automatic int key_index(logic [7:0] code);
    int idx;
    idx = -1;
    for (int i = 0; i < key_state_w; i++) begin
      if (key_codes[i] == code) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  function automatic logic [9:0] player_word(logic [20:0] keys, logic [10:0] joy, bit second);
    logic [9:0] word;
    for (int b = 0; b < player_w; b++) begin
      word[b] = (second ? keys[p2_keys[b]] : keys[p1_keys[b]]) | joy[joy_bits[b]];
    end
    return word;
  endfunction

  // Advances the model by one row and records what the DUT must show
  task automatic add_row(string name, bit evt, bit pressed, logic [7:0] code,
                         logic [10:0] j0, logic [10:0] j1, logic [31:0] st,
                         logic [31:0] addr);
    row_t r;
    int   idx;
    idx = key_index(code);
    if (evt) begin
      model_toggle = ~model_toggle;
      if (idx >= 0) begin
        model_keys[idx] = pressed;
      end
    end
    r.name      = name;
    r.key       = {model_toggle, pressed, 1'b0, code};
    r.joy0      = j0;
    r.joy1      = j1;
    r.status    = st;
    r.addr      = addr;
    r.exp_p1    = player_word(model_keys, j0, 1'b0);
    r.exp_p2    = player_word(model_keys, j1, 1'b1);
    r.exp_pause = model_keys[key_idx_p] | j0[joy_pause] | j1[joy_pause];
    // Wide has priority over vertical
    r.exp_arx   = st[status_wide_bit] ? 8'd16 : (st[status_vertical_bit] ? 8'd3 : 8'd4);
    r.exp_ary   = st[status_wide_bit] ? 8'd9 : (st[status_vertical_bit] ? 8'd4 : 8'd3);
    r.exp_flip  = st[status_flip_bit];
    r.exp_debug = st[status_debug_bit];
    r.exp_ddr   = {ddr_window, addr[27:3]};
    rows.push_back(r);
  endtask

  //////////////////////////////////////////////////
  // Check helpers
  //////////////////////////////////////////////////
  task automatic start_test();
    test_ok = 1'b1;
  endtask

  task automatic check_field(string field, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      if (test_ok) begin
        bad_field = field;
        bad_exp   = exp;
        bad_act   = act;
      end
      test_ok = 1'b0;
    end
  endtask

  task automatic finish_test(string name);
    if (test_ok) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s %s expected %0h actual %0h", name, bad_field, bad_exp, bad_act);
    end
  endtask

  // Resets must rise exactly tb_reset_stages edges after the sources clear
  task automatic check_release(bit core_follows);
    for (int k = 1; k <= tb_reset_stages; k++) begin
      @(negedge clk_sys);
      check_field("cpu_rst_n", k == tb_reset_stages, cpu_rst_n);
      check_field("core_rst_n", core_follows ? (k == tb_reset_stages) : 1'b1, core_rst_n);
    end
  endtask

  // Menu reset or user button holds only the CPU
  task automatic cpu_only_reset(string name, bit use_button);
    start_test();
    user_button = use_button;
    status      = use_button ? 32'h0 : 32'h1;
    repeat (4) begin
      @(negedge clk_sys);
      check_field("cpu_rst_n", 1'b0, cpu_rst_n);
      check_field("core_rst_n", 1'b1, core_rst_n);
    end
    user_button = 1'b0;
    status      = 32'h0;
    check_release(1'b0);
    finish_test(name);
  endtask

  // Watchdog
  always @(posedge clk_sys) begin
    cycle_count++;
    if (cycle_count > timeout_limit) begin
      $display("Timeout after %0d cycles, the test sequence did not finish", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    bit    evt;
    string name;
    void'($urandom(32'h2a95));
    pass_count    = 0;
    fail_count    = 0;
    cycle_count   = 0;
    timeout_limit = 1000;
    model_keys    = '0;
    model_toggle  = 1'b0;
    rst_n         = 1'b0;
    pll_locked    = 1'b0;
    ps2_key       = '0;
    joystick_0    = '0;
    joystick_1    = '0;
    status        = '0;
    user_button   = 1'b0;
    core_ddr_addr = '0;

    key_codes = '{scan_up, scan_down, scan_left, scan_right, scan_ctrl, scan_alt, scan_space,
                  scan_1, scan_2, scan_5, scan_6, scan_9, scan_0, scan_a, scan_s, scan_q,
                  scan_r, scan_f, scan_d, scan_g, scan_p};
    p1_keys   = '{key_idx_up, key_idx_down, key_idx_left, key_idx_right, key_idx_ctrl,
                  key_idx_alt, key_idx_space, key_idx_1, key_idx_5, key_idx_9};
    p2_keys   = '{key_idx_r, key_idx_f, key_idx_d, key_idx_g, key_idx_a,
                  key_idx_s, key_idx_q, key_idx_2, key_idx_6, key_idx_0};
    joy_bits  = '{joy_up, joy_down, joy_left, joy_right, joy_b1,
                  joy_b2, joy_b3, joy_start, joy_coin, joy_service};

    // Directed rows
    add_row("idle", 0, 0, 8'h00, '0, '0, '0, '0);
    add_row("press_up", 1, 1, scan_up, '0, '0, '0, 32'h0000_0008);
    add_row("press_r", 1, 1, scan_r, '0, '0, '0, 32'hffff_fff8);
    add_row("repeat_toggle", 0, 1, scan_ctrl, '0, '0, '0, '0);
    add_row("unknown_code", 1, 1, 8'h5a, '0, '0, '0, '0);
    add_row("release_up", 1, 0, scan_up, '0, '0, '0, '0);
    add_row("press_p", 1, 1, scan_p, '0, '0, '0, '0);
    add_row("release_p", 1, 0, scan_p, '0, '0, '0, '0);
    add_row("press_5", 1, 1, scan_5, '0, '0, '0, '0);
    add_row("pause_joy0", 0, 0, 8'h00, 11'h200, '0, '0, '0);
    add_row("pause_joy1", 0, 0, 8'h00, '0, 11'h200, '0, '0);
    add_row("aspect_wide", 0, 0, 8'h00, '0, '0, 32'h2, '0);
    add_row("aspect_vertical", 0, 0, 8'h00, '0, '0, 32'h4, '0);
    add_row("wide_over_vertical", 0, 0, 8'h00, '0, '0, 32'h6, '0);
    add_row("flip_debug", 0, 0, 8'h00, '0, '0, 32'h88, '0);
    add_row("aspect_default", 0, 0, 8'h00, '0, '0, '0, '0);

    // Random rows, status reset bit kept clear
    for (int i = 0; i < 16; i++) begin
      evt  = ($urandom % 4) != 0;
      name = $sformatf("random_%0d", i);
      add_row(name, evt, $urandom % 2, key_codes[$urandom_range(key_state_w - 1, 0)],
              $urandom, $urandom, $urandom & ~32'h1, $urandom);
    end

    // Limit from the table length
    timeout_limit = rows.size() * 4 + 20;

    // Reset sequencing
    repeat (3) @(negedge clk_sys);
    start_test();
    check_field("core_rst_n", 1'b0, core_rst_n);
    check_field("cpu_rst_n", 1'b0, cpu_rst_n);
    finish_test("reset_hold");

    rst_n = 1'b1;
    start_test();
    repeat (2) @(negedge clk_sys);
    check_field("core_rst_n", 1'b0, core_rst_n);
    check_field("cpu_rst_n", 1'b0, cpu_rst_n);
    finish_test("pll_unlocked");

    start_test();
    pll_locked = 1'b1;
    check_release(1'b1);
    finish_test("pll_release");

    cpu_only_reset("user_button_reset", 1'b1);
    cpu_only_reset("menu_reset", 1'b0);

    // Table loop, checked one cycle after each row is driven
    foreach (rows[i]) begin
      ps2_key       = rows[i].key;
      joystick_0    = rows[i].joy0;
      joystick_1    = rows[i].joy1;
      status        = rows[i].status;
      core_ddr_addr = rows[i].addr;
      @(negedge clk_sys);
      start_test();
      check_field("player_1", rows[i].exp_p1, player_1);
      check_field("player_2", rows[i].exp_p2, player_2);
      check_field("pause", rows[i].exp_pause, pause);
      check_field("video_arx", rows[i].exp_arx, video_arx);
      check_field("video_ary", rows[i].exp_ary, video_ary);
      check_field("flip", rows[i].exp_flip, flip);
      check_field("debug", rows[i].exp_debug, debug);
      check_field("ddram_addr", rows[i].exp_ddr, ddram_addr);
      finish_test(rows[i].name);
    end

    $display("Tests: %0d passed, %0d failed, %0d assertion errors",
             pass_count, fail_count, UUT.u_assertions.assert_errors);
    if (fail_count == 0 && UUT.u_assertions.assert_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- files.f
input_pkg.sv
platform_pkg.sv
ps2_key_decoder.sv
player_input_merge.sv
reset_sequencer.sv
core_config.sv
arcade_io_top.sv
arcade_io_assertions.sv
tb_arcade_io.sv

//--- Bender.yml
package:
  name: arcade_io

sources:
  - files:
      - input_pkg.sv
      - platform_pkg.sv
      - ps2_key_decoder.sv
      - player_input_merge.sv
      - reset_sequencer.sv
      - core_config.sv
      - arcade_io_top.sv
  - target: test
    files:
      - arcade_io_assertions.sv
      - tb_arcade_io.sv
